// ==== build.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch_pc.sv
hw/decoder.sv
hw/regfile.sv
hw/hazard_detect.sv
hw/regwalls.sv
hw/execute_unit.sv
hw/pipeline_top.sv
test/writeback_checker.sv
test/pipeline_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module pipeline_tb -o pipeline_sim
./obj_dir/pipeline_sim > sim.log 2>&1
cat sim.log
if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi

// ==== test/pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb
	import isa_pkg::*;
	import pipe_pkg::*;
();

	localparam int PROG_LEN     = 21;
	localparam int CYCLE_LIMIT  = 4 * PROG_LEN + 40;
	localparam int DRAIN_CYCLES = 8;   // Room for a stray write to show up after the last one.

	logic                  clock;
	logic                  reset;
	logic                  enable;
	logic [DATA_W-1:0]     instruction;
	logic [DATA_W-1:0]     fetch_pc;
	logic                  wb_strobe;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [DATA_W-1:0]     wb_data;
	logic                  all_seen;
	int                    write_count;
	int                    error_count;
	logic [DATA_W-1:0]     program_words [PROG_LEN];
	int                    cycle;
	int                    drain;
	logic                  timed_out;

	function automatic logic [DATA_W-1:0] rtype_word(input funct_e funct, input int rd,
		input int rs, input int rt);
		return {RTYPE, REG_ADDR_W'(rs), REG_ADDR_W'(rt), REG_ADDR_W'(rd), 5'd0, funct};
	endfunction

	function automatic logic [DATA_W-1:0] itype_word(input opcode_e op, input int rt,
		input int rs, input logic [IMM_W-1:0] value);
		return {op, REG_ADDR_W'(rs), REG_ADDR_W'(rt), value};
	endfunction

	function automatic logic [DATA_W-1:0] jtype_word(input opcode_e op, input int index);
		return {op, INDEX_W'(index)};
	endfunction

	// Words past the end of the program read as zero, which decodes to no write.
	function automatic logic [DATA_W-1:0] word_at(input logic [DATA_W-1:0] addr);
		if (addr < DATA_W'(4 * PROG_LEN))
			return program_words[addr[6:2]];
		return '0;
	endfunction

	pipeline_top dut0 (
		.clock(clock), .reset(reset), .enable(enable), .instruction(instruction),
		.fetch_pc(fetch_pc), .wb_strobe(wb_strobe), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	writeback_checker writeback_check0 (
		.clock(clock), .reset(reset), .enable(enable), .fetch_pc(fetch_pc),
		.wb_strobe(wb_strobe), .wb_addr(wb_addr), .wb_data(wb_data),
		.all_seen(all_seen), .write_count(write_count), .error_count(error_count)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		void'($urandom(32'hc9c7_f737));
		reset       = 1'b1;
		enable      = 1'b1;
		instruction = '0;
		timed_out   = 1'b0;
		cycle       = 0;
		drain       = 0;
		program_words[0]  = itype_word(ADDI, 1, 0, 16'd5);
		program_words[1]  = itype_word(ORI, 2, 0, 16'h8001);   // Zero-extended.
		program_words[2]  = itype_word(LUI, 3, 0, 16'h1234);
		program_words[3]  = itype_word(ADDI, 4, 0, 16'hfffd);
		program_words[4]  = rtype_word(ADD, 5, 2, 4);
		program_words[5]  = rtype_word(SUB, 6, 5, 1);
		program_words[6]  = rtype_word(AND, 7, 6, 2);
		program_words[7]  = rtype_word(OR, 8, 7, 3);
		program_words[8]  = rtype_word(SLT, 9, 4, 8);   // Negative against positive.
		program_words[9]  = itype_word(ADDI, 10, 0, 16'hfff9);
		program_words[10] = itype_word(ORI, 13, 0, 16'h00f0);
		program_words[11] = rtype_word(ADD, 12, 9, 1);   // Reads r9 from three words back.
		program_words[12] = rtype_word(SLT, 11, 10, 4);
		program_words[13] = jtype_word(J, 15);
		program_words[14] = itype_word(ADDI, 14, 0, 16'h0bad);
		program_words[15] = jtype_word(JAL, 18);
		program_words[16] = itype_word(ADDI, 14, 0, 16'h0bad);
		program_words[17] = itype_word(ORI, 14, 0, 16'hdead);
		program_words[18] = itype_word(ADDI, 0, 1, 16'd7);
		program_words[19] = rtype_word(ADD, 16, 0, LINK_REG);
		program_words[20] = itype_word(ADDI, 18, 16, 16'd1);
		repeat (8) @(negedge clock);
		reset = 1'b0;
		while (!timed_out && drain < DRAIN_CYCLES) begin
			instruction = word_at(fetch_pc);
			enable      = ($urandom_range(3) != 0);
			@(negedge clock);
			cycle++;
			if (all_seen)
				drain++;
			if (cycle >= CYCLE_LIMIT)
				timed_out = 1'b1;
		end
		if (timed_out)
			$display("Timeout: the run reached its limit of %0d cycles.", CYCLE_LIMIT);
		if (!all_seen)
			$display("Not every expected write appeared on the writeback port.");
		$display("Writes seen: %0d, errors: %0d, cycles: %0d.", write_count, error_count, cycle);
		if (timed_out || !all_seen || error_count != 0)
			$display("Simulation FAILED");
		else
			$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/writeback_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_checker
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  enable,
	input  wire [DATA_W-1:0]     fetch_pc,
	input  wire                  wb_strobe,
	input  wire [REG_ADDR_W-1:0] wb_addr,
	input  wire [DATA_W-1:0]     wb_data,
	output logic                 all_seen,
	output int                   write_count,
	output int                   error_count
);

	localparam int NUM_WRITES = 16;

	logic [REG_ADDR_W+DATA_W-1:0] expected [NUM_WRITES];
	logic [DATA_W-1:0]            pc_before;
	logic                         enable_before;

	// Register and value of each write, in program order.
	initial begin
		expected = '{
			{5'd1, 32'h0000_0005}, {5'd2, 32'h0000_8001},
			{5'd3, 32'h1234_0000}, {5'd4, 32'hffff_fffd},
			{5'd5, 32'h0000_7ffe}, {5'd6, 32'h0000_7ff9},
			{5'd7, 32'h0000_0001}, {5'd8, 32'h1234_0001},
			{5'd9, 32'h0000_0001}, {5'd10, 32'hffff_fff9},
			{5'd13, 32'h0000_00f0}, {5'd12, 32'h0000_0006},
			{5'd11, 32'h0000_0001}, {REG_ADDR_W'(LINK_REG), 32'h0000_0040},
			{5'd16, 32'h0000_0040}, {5'd18, 32'h0000_0041}
		};
	end

	task automatic check_write();
		logic [REG_ADDR_W-1:0] exp_addr;
		logic [DATA_W-1:0]     exp_data;
		if (write_count >= NUM_WRITES) begin
			$display("Extra write to r%0d of %h at %0t after all expected writes.",
				wb_addr, wb_data, $time);
			error_count++;
		end else begin
			{exp_addr, exp_data} = expected[write_count[3:0]];
			if (wb_addr != exp_addr || wb_data != exp_data) begin
				$display("FAILED at %0t: write %0d went to r%0d with %h, expected r%0d with %h.",
					$time, write_count, wb_addr, wb_data, exp_addr, exp_data);
				error_count++;
			end
			write_count++;
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			write_count   = 0;
			error_count   = 0;
			enable_before = 1'b1;
		end else begin
			if (!enable_before && fetch_pc != pc_before) begin   // Fetch must hold.
				$display("FAILED at %0t: fetch_pc moved from %h to %h while enable was low.",
					$time, pc_before, fetch_pc);
				error_count++;
			end
			if (enable && wb_strobe)
				check_write();
		end
		pc_before     = fetch_pc;
		enable_before = reset ? 1'b1 : enable;
	end

	assign all_seen = (write_count == NUM_WRITES);

endmodule

`default_nettype wire

// ==== hw/pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_top
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   enable,
	input  wire  [DATA_W-1:0]     instruction,
	output logic [DATA_W-1:0]     fetch_pc,
	output logic                  wb_strobe,
	output logic [REG_ADDR_W-1:0] wb_addr,
	output logic [DATA_W-1:0]     wb_data
);

	logic [DATA_W-1:0]     reg1_instruction;
	logic [DATA_W-1:0]     reg1_current_pc;
	alu_op_e               alu_op;
	logic                  alu_src_imm;
	logic [DATA_W-1:0]     imm;
	wb_sel_e               wb_sel;
	logic                  reg_write;
	logic [REG_ADDR_W-1:0] write_addr;
	logic                  rs_used;
	logic                  rt_used;
	logic                  jump_taken;
	logic [DATA_W-1:0]     jump_target;
	logic [DATA_W-1:0]     rs_data;
	logic [DATA_W-1:0]     rt_data;
	logic                  stall;
	alu_op_e               reg2_alu_op;
	logic [DATA_W-1:0]     reg2_operand_a;
	logic [DATA_W-1:0]     reg2_operand_b;
	wb_sel_e               reg2_wb_sel;
	logic [DATA_W-1:0]     reg2_link_pc;
	logic                  reg2_reg_write;
	logic [REG_ADDR_W-1:0] reg2_write_addr;
	logic                  reg3_reg_write;
	logic [REG_ADDR_W-1:0] reg3_write_addr;
	logic [DATA_W-1:0]     result;

	fetch_pc fetch0 (
		.clock(clock), .reset(reset), .enable(enable), .stall(stall),
		.jump_taken(jump_taken), .jump_target(jump_target), .pc(fetch_pc)
	);

	decoder decoder0 (
		.instruction(reg1_instruction), .current_pc(reg1_current_pc),
		.alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm(imm), .wb_sel(wb_sel),
		.reg_write(reg_write), .write_addr(write_addr), .rs_used(rs_used),
		.rt_used(rt_used), .jump_taken(jump_taken), .jump_target(jump_target)
	);

	regfile regfile0 (
		.clock(clock), .reset(reset),
		.rs_addr(reg1_instruction[RS_LSB +: REG_ADDR_W]),
		.rt_addr(reg1_instruction[RT_LSB +: REG_ADDR_W]),
		.rs_data(rs_data), .rt_data(rt_data),
		.write_strobe(wb_strobe), .write_addr(wb_addr), .write_data(wb_data)
	);

	hazard_detect hazard0 (
		.rs_used(rs_used), .rt_used(rt_used),
		.rs_addr(reg1_instruction[RS_LSB +: REG_ADDR_W]),
		.rt_addr(reg1_instruction[RT_LSB +: REG_ADDR_W]),
		.ex_write(reg2_reg_write), .ex_addr(reg2_write_addr),
		.mem_write(reg3_reg_write), .mem_addr(reg3_write_addr), .stall(stall)
	);

	regwalls regwalls0 (
		.clock(clock), .reset(reset), .enable(enable), .stall(stall), .flush(jump_taken),
		.pc(fetch_pc), .instruction(instruction),
		.reg1_instruction(reg1_instruction), .reg1_current_pc(reg1_current_pc),
		.alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm(imm), .wb_sel(wb_sel),
		.reg_write(reg_write), .write_addr(write_addr), .rs_data(rs_data), .rt_data(rt_data),
		.reg2_alu_op(reg2_alu_op), .reg2_operand_a(reg2_operand_a),
		.reg2_operand_b(reg2_operand_b), .reg2_wb_sel(reg2_wb_sel),
		.reg2_link_pc(reg2_link_pc), .reg2_reg_write(reg2_reg_write),
		.reg2_write_addr(reg2_write_addr), .result(result),
		.reg3_reg_write(reg3_reg_write), .reg3_write_addr(reg3_write_addr),
		.reg3_write_data(),
		.reg4_reg_write(wb_strobe), .reg4_write_addr(wb_addr), .reg4_write_data(wb_data)
	);

	execute_unit execute0 (
		.alu_op(reg2_alu_op), .operand_a(reg2_operand_a), .operand_b(reg2_operand_b),
		.wb_sel(reg2_wb_sel), .link_pc(reg2_link_pc), .result(result)
	);

endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire alu_op_e      alu_op,
	input  wire [DATA_W-1:0]  operand_a,
	input  wire [DATA_W-1:0]  operand_b,
	input  wire wb_sel_e      wb_sel,
	input  wire [DATA_W-1:0]  link_pc,
	output logic [DATA_W-1:0] result
);

	logic [DATA_W-1:0] alu_value;

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_value = operand_a + operand_b;
			ALU_SUB: alu_value = operand_a - operand_b;
			ALU_AND: alu_value = operand_a & operand_b;
			ALU_OR:  alu_value = operand_a | operand_b;
			ALU_SLT: alu_value = DATA_W'($signed(operand_a) < $signed(operand_b));
			ALU_LUI: alu_value = operand_b << IMM_W;   // Immediate into the upper half.
			default: alu_value = '0;
		endcase
	end

	assign result = (wb_sel == WB_LINK) ? link_pc : alu_value;

endmodule

`default_nettype wire

// ==== hw/regwalls.sv ====
`timescale 1ns/1ps
`default_nettype none

module regwalls
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   enable,
	input  wire                   stall,
	input  wire                   flush,

	input  wire  [DATA_W-1:0]     pc,
	input  wire  [DATA_W-1:0]     instruction,
	output logic [DATA_W-1:0]     reg1_instruction,
	output logic [DATA_W-1:0]     reg1_current_pc,

	input  wire alu_op_e          alu_op,
	input  wire                   alu_src_imm,
	input  wire  [DATA_W-1:0]     imm,
	input  wire wb_sel_e          wb_sel,
	input  wire                   reg_write,
	input  wire  [REG_ADDR_W-1:0] write_addr,
	input  wire  [DATA_W-1:0]     rs_data,
	input  wire  [DATA_W-1:0]     rt_data,
	output alu_op_e               reg2_alu_op,
	output logic [DATA_W-1:0]     reg2_operand_a,
	output logic [DATA_W-1:0]     reg2_operand_b,
	output wb_sel_e               reg2_wb_sel,
	output logic [DATA_W-1:0]     reg2_link_pc,
	output logic                  reg2_reg_write,
	output logic [REG_ADDR_W-1:0] reg2_write_addr,

	input  wire  [DATA_W-1:0]     result,
	output logic                  reg3_reg_write,
	output logic [REG_ADDR_W-1:0] reg3_write_addr,
	output logic [DATA_W-1:0]     reg3_write_data,

	output logic                  reg4_reg_write,
	output logic [REG_ADDR_W-1:0] reg4_write_addr,
	output logic [DATA_W-1:0]     reg4_write_data
);

	always_ff @(posedge clock) begin
		if (reset) begin
			reg1_instruction <= '0;
			reg1_current_pc  <= '0;
			reg2_alu_op      <= ALU_ADD;
			reg2_operand_a   <= '0;
			reg2_operand_b   <= '0;
			reg2_wb_sel      <= WB_ALU;
			reg2_link_pc     <= '0;
			reg2_reg_write   <= 1'b0;
			reg2_write_addr  <= '0;
			reg3_reg_write   <= 1'b0;
			reg3_write_addr  <= '0;
			reg3_write_data  <= '0;
			reg4_reg_write   <= 1'b0;
			reg4_write_addr  <= '0;
			reg4_write_data  <= '0;
		end else if (enable) begin
			if (flush && !stall) begin   // The word behind a taken jump is dropped.
				reg1_instruction <= '0;
				reg1_current_pc  <= '0;
			end else if (!stall) begin
				reg1_instruction <= instruction;
				reg1_current_pc  <= pc;
			end

			if (stall) begin
				// Bubble into execute while decode waits.
				reg2_alu_op     <= ALU_ADD;
				reg2_operand_a  <= '0;
				reg2_operand_b  <= '0;
				reg2_wb_sel     <= WB_ALU;
				reg2_link_pc    <= '0;
				reg2_reg_write  <= 1'b0;
				reg2_write_addr <= '0;
			end else begin
				reg2_alu_op     <= alu_op;
				reg2_operand_a  <= rs_data;
				reg2_operand_b  <= alu_src_imm ? imm : rt_data;
				reg2_wb_sel     <= wb_sel;
				reg2_link_pc    <= reg1_current_pc + PC_STEP;
				reg2_reg_write  <= reg_write;
				reg2_write_addr <= write_addr;
			end

			reg3_reg_write  <= reg2_reg_write;
			reg3_write_addr <= reg2_write_addr;
			reg3_write_data <= result;   // Memory stage only carries the value on.

			reg4_reg_write  <= reg3_reg_write;
			reg4_write_addr <= reg3_write_addr;
			reg4_write_data <= reg3_write_data;
		end
	end

	// A stall only ever waits on a write still pending in execute or memory.
	assert property (@(posedge clock) disable iff (reset)
		(enable && stall) |-> (reg2_reg_write || reg3_reg_write))
		else $error("Stall raised with no write pending in execute or memory.");

endmodule

`default_nettype wire

// ==== hw/hazard_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_detect
	import isa_pkg::*;
(
	input  wire                  rs_used,
	input  wire                  rt_used,
	input  wire [REG_ADDR_W-1:0] rs_addr,
	input  wire [REG_ADDR_W-1:0] rt_addr,
	input  wire                  ex_write,
	input  wire [REG_ADDR_W-1:0] ex_addr,
	input  wire                  mem_write,
	input  wire [REG_ADDR_W-1:0] mem_addr,
	output logic                 stall
);

	logic rs_hit;
	logic rt_hit;

	// Writeback needs no check here, the register file passes that value through.
	assign rs_hit = rs_used &&
		((ex_write && ex_addr == rs_addr) || (mem_write && mem_addr == rs_addr));
	assign rt_hit = rt_used &&
		((ex_write && ex_addr == rt_addr) || (mem_write && mem_addr == rt_addr));

	assign stall = rs_hit || rt_hit;

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire                   clock,
	input  wire                   reset,
	input  wire  [REG_ADDR_W-1:0] rs_addr,
	input  wire  [REG_ADDR_W-1:0] rt_addr,
	output logic [DATA_W-1:0]     rs_data,
	output logic [DATA_W-1:0]     rt_data,
	input  wire                   write_strobe,
	input  wire  [REG_ADDR_W-1:0] write_addr,
	input  wire  [DATA_W-1:0]     write_data
);

	logic [DATA_W-1:0] regs [2**REG_ADDR_W];

	// A read of the register being written sees the new value.
	function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (write_strobe && write_addr == addr)
			return write_data;
		return regs[addr];
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++)
				regs[i] <= '0;
		end else if (write_strobe && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

	always_comb begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

	// Decode masks r0 destinations, so none should survive down to writeback.
	assert property (@(posedge clock) disable iff (reset) write_strobe |-> write_addr != '0)
		else $error("Writeback targets r0.");

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire  [DATA_W-1:0]     instruction,
	input  wire  [DATA_W-1:0]     current_pc,
	output alu_op_e               alu_op,
	output logic                  alu_src_imm,
	output logic [DATA_W-1:0]     imm,
	output wb_sel_e               wb_sel,
	output logic                  reg_write,
	output logic [REG_ADDR_W-1:0] write_addr,
	output logic                  rs_used,
	output logic                  rt_used,
	output logic                  jump_taken,
	output logic [DATA_W-1:0]     jump_target
);

	opcode_e               opcode;
	funct_e                funct;
	logic [REG_ADDR_W-1:0] rt_field;
	logic [REG_ADDR_W-1:0] rd_field;
	logic [IMM_W-1:0]      imm_field;
	logic [DATA_W-1:0]     pc_plus4;
	logic                  dest_valid;

	assign opcode    = opcode_e'(instruction[OPCODE_LSB +: OPCODE_W]);
	assign funct     = funct_e'(instruction[FUNCT_LSB +: FUNCT_W]);
	assign rt_field  = instruction[RT_LSB +: REG_ADDR_W];
	assign rd_field  = instruction[RD_LSB +: REG_ADDR_W];
	assign imm_field = instruction[IMM_LSB +: IMM_W];

	assign pc_plus4    = current_pc + PC_STEP;
	assign jump_target = {pc_plus4[DATA_W-1 -: DATA_W-INDEX_W-2],
		instruction[INDEX_LSB +: INDEX_W], 2'b00};

	always_comb begin
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		imm         = {{(DATA_W-IMM_W){imm_field[IMM_W-1]}}, imm_field};
		wb_sel      = WB_ALU;
		dest_valid  = 1'b0;
		write_addr  = rt_field;
		rs_used     = 1'b0;
		rt_used     = 1'b0;
		jump_taken  = 1'b0;
		case (opcode)
			RTYPE: begin
				write_addr = rd_field;
				dest_valid = 1'b1;
				rs_used    = 1'b1;
				rt_used    = 1'b1;
				case (funct)
					ADD: alu_op = ALU_ADD;
					SUB: alu_op = ALU_SUB;
					AND: alu_op = ALU_AND;
					OR:  alu_op = ALU_OR;
					SLT: alu_op = ALU_SLT;
					default: begin   // Also covers the all-zero word.
						dest_valid = 1'b0;
						rs_used    = 1'b0;
						rt_used    = 1'b0;
					end
				endcase
			end
			ADDI: begin
				alu_src_imm = 1'b1;
				dest_valid  = 1'b1;
				rs_used     = 1'b1;
			end
			ORI: begin
				alu_op      = ALU_OR;
				alu_src_imm = 1'b1;
				imm         = {{(DATA_W-IMM_W){1'b0}}, imm_field};
				dest_valid  = 1'b1;
				rs_used     = 1'b1;
			end
			LUI: begin
				alu_op      = ALU_LUI;
				alu_src_imm = 1'b1;
				dest_valid  = 1'b1;
			end
			J: jump_taken = 1'b1;
			JAL: begin
				jump_taken = 1'b1;
				wb_sel     = WB_LINK;
				write_addr = REG_ADDR_W'(LINK_REG);
				dest_valid = 1'b1;
			end
			default: dest_valid = 1'b0;
		endcase
	end

	assign reg_write = dest_valid && (write_addr != '0);   // r0 is never written.

endmodule

`default_nettype wire

// ==== hw/fetch_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc
	import pipe_pkg::*;
(
	input  wire                clock,
	input  wire                reset,
	input  wire                enable,
	input  wire                stall,
	input  wire                jump_taken,
	input  wire  [DATA_W-1:0]  jump_target,
	output logic [DATA_W-1:0]  pc
);

	logic [DATA_W-1:0] next_pc;

	// A jump is resolved in decode, so the word already fetched after it is dropped.
	assign next_pc = jump_taken ? jump_target : pc + PC_STEP;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (enable && !stall) begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	localparam int DATA_W  = 32;
	localparam int PC_STEP = 4;   // Byte distance between instruction words.

	localparam int LINK_REG = 31;
	localparam logic [DATA_W-1:0] RESET_PC = '0;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	// Writeback takes either the ALU value or the return address.
	typedef enum logic {
		WB_ALU,
		WB_LINK
	} wb_sel_e;

endpackage

`default_nettype wire

// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int IMM_W      = 16;
	localparam int INDEX_W    = 26;

	// Field positions inside the instruction word.
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB     = 21;
	localparam int RT_LSB     = 16;
	localparam int RD_LSB     = 11;
	localparam int FUNCT_LSB  = 0;
	localparam int IMM_LSB    = 0;
	localparam int INDEX_LSB  = 0;

	typedef enum logic [OPCODE_W-1:0] {
		RTYPE = 6'd0,
		J     = 6'd2,
		JAL   = 6'd3,
		ADDI  = 6'd8,
		ORI   = 6'd13,
		LUI   = 6'd15
	} opcode_e;

	typedef enum logic [FUNCT_W-1:0] {
		ADD = 6'd32,
		SUB = 6'd34,
		AND = 6'd36,
		OR  = 6'd37,
		SLT = 6'd42
	} funct_e;

endpackage

`default_nettype wire
